/* verilog/mdr_pkg.sv */
//==============================
// widths, op codes and shared types
// of the multiply/divide/sqrt unit
//==============================
`default_nettype none

package mdr_pkg;

	//==============================
	// widths
	//==============================
	localparam int N   = 8;	// operand width
	localparam int TAM = 5;	// display digits
	localparam int C   = 4;	// iteration count width

	// iterations per operation
	localparam logic [C-1:0] ITER_LONG  = C'(N);	// mul, div and the reserved op
	localparam logic [C-1:0] ITER_SHORT = C'(N/2);	// sqrt eats two bits per step

	//==============================
	// op codes
	//==============================
	typedef logic [1:0] op_t;

	localparam op_t OP_MUL  = 2'b00;
	localparam op_t OP_DIV  = 2'b01;
	localparam op_t OP_SQRT = 2'b10;
	localparam op_t OP_RSV  = 2'b11;	// reserved, flagged as error

	//==============================
	// data words
	//==============================
	typedef logic [N-1:0]   word_t;
	typedef logic [2*N-1:0] dword_t;

	// divide and sqrt split the accumulator in halves
	typedef struct packed {
		word_t rem;	// upper half
		word_t quo;	// lower half, quotient or root
	} mdr_qr_t;

	// one accumulator, read as a product or as rem:quo
	typedef union packed {
		dword_t  prod;
		mdr_qr_t qr;
	} mdr_acc_t;

	typedef struct packed {
		word_t x;
		word_t y;
	} operands_t;

	//==============================
	// display
	//==============================
	typedef logic [3:0]     bcd_t;
	typedef bcd_t [TAM-1:0] bcd_bus_t;	// digit 0 is the least significant
	typedef logic [6:0]     seg_t;	// bit 6 is segment a, bit 0 is g

endpackage

`default_nettype wire

/* verilog/operand_loader.sv */
//==============================
// operand loader, steers load
// pulses into the x and y registers
//==============================
`default_nettype none

module operand_loader import mdr_pkg::*;
(
	input  wire        clk,
	input  wire        reset,
	input  wire        load,
	input  wire word_t data,
	output operands_t  operands,
	output logic       load_x,
	output logic       load_y
);

	logic sel_y;	// next load goes to y

	// pointer and loaded flags
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			sel_y  <= 1'b0;
			load_x <= 1'b0;
			load_y <= 1'b0;
		end
		else if (load)
		begin
			sel_y <= ~sel_y;
			if (sel_y)
				load_y <= 1'b1;
			else
			begin
				load_x <= 1'b1;
				load_y <= 1'b0;	// x starts a fresh pair
			end
		end
	end

	// operand words
	always_ff @(posedge clk)
	begin
		if (load && !sel_y)
			operands.x <= data;
		if (load && sel_y)
			operands.y <= data;
	end

endmodule

`default_nettype wire

/* verilog/step_counter.sv */
//==============================
// iteration counter, run level
// and ready flag
//==============================
`default_nettype none

module step_counter import mdr_pkg::*;
(
	input  wire      clk,
	input  wire      reset,
	input  wire      start,
	input  wire op_t op,
	output logic     run,
	output logic     last,
	output logic     ready
);

	logic [C-1:0] count;	// iterations left
	logic         go;

	assign go = start && !run;	// a start while busy is dropped

	// last iteration of the current run
	assign last = run && (count == C'(1));

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			count <= '0;
			run   <= 1'b0;
			ready <= 1'b1;
		end
		else if (go)
		begin
			count <= (op == OP_SQRT) ? ITER_SHORT : ITER_LONG;
			run   <= 1'b1;
			ready <= 1'b0;
		end
		else if (run)
		begin
			count <= count - C'(1);
			if (last)
				run <= 1'b0;
		end
		else if (!ready)
		begin
			// one cycle after the final iteration
			ready <= 1'b1;
		end
	end

endmodule

`default_nettype wire

/* verilog/mdr_datapath.sv */
//==============================
// accumulator and iteration logic
// for multiply, divide and sqrt
//==============================
`default_nettype none

module mdr_datapath import mdr_pkg::*;
(
	input  wire            clk,
	input  wire            reset,
	input  wire            start,
	input  wire            run,
	input  wire            last,
	input  wire op_t       op,
	input  wire operands_t operands,
	output mdr_acc_t       acc,
	output logic           error
);

	logic         go;
	logic         bad;	// op cannot run with these operands
	word_t        shf;	// multiplier or radicand, consumed msb first
	dword_t       mul_sum;
	dword_t       mul_next;
	logic [N:0]   div_part;	// shifted rem with the next dividend bit
	logic [N+1:0] div_diff;
	logic [N+1:0] sq_part;	// rem with the next two radicand bits
	logic [N+1:0] sq_trial;	// 4*root + 1
	logic [N+2:0] sq_diff;
	mdr_acc_t     acc_next;

	assign go  = start && !run;
	assign bad = (op == OP_RSV) || ((op == OP_DIV) && (operands.y == '0));

	//==============================
	// per-step arithmetic
	//==============================
	// multiply, add y for the current bit and shift on all but the last step
	assign mul_sum  = acc.prod + (shf[N-1] ? dword_t'(operands.y) : '0);
	assign mul_next = last ? mul_sum : (mul_sum << 1);

	// restoring divide
	assign div_part = {acc.qr.rem, acc.qr.quo[N-1]};
	assign div_diff = {1'b0, div_part} - {2'b00, operands.y};

	// digit-by-digit square root
	assign sq_part  = {acc.qr.rem, shf[N-1:N-2]};
	assign sq_trial = {acc.qr.quo, 2'b01};
	assign sq_diff  = {1'b0, sq_part} - {1'b0, sq_trial};

	always_comb
	begin
		acc_next = acc;
		case (op)
			OP_MUL:
				acc_next.prod = mul_next;
			OP_DIV:
			begin
				if (!div_diff[N+1])	// difference not negative
				begin
					acc_next.qr.rem = div_diff[N-1:0];
					acc_next.qr.quo = {acc.qr.quo[N-2:0], 1'b1};
				end
				else
				begin
					acc_next.qr.rem = div_part[N-1:0];
					acc_next.qr.quo = {acc.qr.quo[N-2:0], 1'b0};
				end
			end
			OP_SQRT:
			begin
				if (!sq_diff[N+2])
				begin
					acc_next.qr.rem = sq_diff[N-1:0];
					acc_next.qr.quo = {acc.qr.quo[N-2:0], 1'b1};
				end
				else
				begin
					acc_next.qr.rem = sq_part[N-1:0];
					acc_next.qr.quo = {acc.qr.quo[N-2:0], 1'b0};
				end
			end
			default:
				acc_next = acc;	// reserved op just holds
		endcase
	end

	//==============================
	// registers
	//==============================
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			acc   <= '0;
			error <= 1'b0;
		end
		else if (go)
		begin
			error <= bad;
			acc   <= '0;
			if ((op == OP_DIV) && !bad)
				acc.qr.quo <= operands.x;	// dividend starts in quo
		end
		else if (run && !error)
			acc <= acc_next;
	end

	// operand bits shift out of the top, two at a time for sqrt
	always_ff @(posedge clk)
	begin
		if (go)
			shf <= operands.x;
		else if (run)
			shf <= (op == OP_SQRT) ? (shf << 2) : (shf << 1);
	end

endmodule

`default_nettype wire

/* verilog/bin_to_bcd.sv */
//==============================
// double dabble conversion of the
// displayed value into bcd digits
//==============================
`default_nettype none

module bin_to_bcd import mdr_pkg::*;
(
	input  wire mdr_acc_t acc,
	input  wire op_t      op,
	output bcd_bus_t      digits
);

	dword_t               value;
	logic [4*TAM+2*N-1:0] sh;	// bcd digits above the binary value

	// product for multiply, quotient or root otherwise
	assign value = (op == OP_MUL) ? acc.prod : dword_t'(acc.qr.quo);

	always_comb
	begin
		sh            = '0;
		sh[2*N-1:0]   = value;
		for (int i = 0; i < 2*N; i++)
		begin
			// fix each digit that would pass 9 after the shift
			for (int d = 0; d < TAM; d++)
			begin
				if (sh[2*N+4*d +: 4] > 4'd4)
					sh[2*N+4*d +: 4] = sh[2*N+4*d +: 4] + 4'd3;
			end
			sh = sh << 1;
		end
		digits = sh[2*N +: 4*TAM];
	end

endmodule

`default_nettype wire

/* verilog/seg7_decoder.sv */
//==============================
// bcd digit to seven segments
//==============================
`default_nettype none

module seg7_decoder import mdr_pkg::*;
(
	input  wire bcd_t digit,
	output seg_t      seg
);

	// segments a..g, high is lit
	always_comb
	begin
		case (digit)
			4'd0:    seg = 7'b1111110;
			4'd1:    seg = 7'b0110000;
			4'd2:    seg = 7'b1101101;
			4'd3:    seg = 7'b1111001;
			4'd4:    seg = 7'b0110011;
			4'd5:    seg = 7'b1011011;
			4'd6:    seg = 7'b1011111;
			4'd7:    seg = 7'b1110000;
			4'd8:    seg = 7'b1111111;
			4'd9:    seg = 7'b1111011;
			default: seg = 7'b0000000;	// not a decimal digit, blank
		endcase
	end

endmodule

`default_nettype wire

/* verilog/top_mdr.sv */
//==============================
// top level of the sequential
// multiply/divide/sqrt unit
//==============================
`default_nettype none

module top_mdr import mdr_pkg::*;
(
	input  wire        clk,
	input  wire        reset,
	input  wire        load,
	input  wire op_t   op,
	input  wire        start,
	input  wire word_t data,
	output word_t      result,
	output word_t      remainder,
	output logic       load_x,
	output logic       load_y,
	output logic       ready,
	output logic       error,
	output seg_t       seg [TAM-1:0]
);

	operands_t operands;
	logic      run;
	logic      last;
	mdr_acc_t  acc;
	bcd_bus_t  digits;

	//==============================
	// control and datapath
	//==============================
	operand_loader loader_i
	(
		.clk      (clk),
		.reset    (reset),
		.load     (load),
		.data     (data),
		.operands (operands),
		.load_x   (load_x),
		.load_y   (load_y)
	);

	step_counter counter_i
	(
		.clk   (clk),
		.reset (reset),
		.start (start),
		.op    (op),
		.run   (run),
		.last  (last),
		.ready (ready)
	);

	mdr_datapath datapath_i
	(
		.clk      (clk),
		.reset    (reset),
		.start    (start),
		.run      (run),
		.last     (last),
		.op       (op),
		.operands (operands),
		.acc      (acc),
		.error    (error)
	);

	// after a multiply these are the product high and low bytes
	assign result    = acc.qr.quo;
	assign remainder = acc.qr.rem;

	//==============================
	// display
	//==============================
	bin_to_bcd bcd_i
	(
		.acc    (acc),
		.op     (op),
		.digits (digits)
	);

	genvar k;
	generate
		for (k = 0; k < TAM; k++)
		begin : gen_seg
			seg7_decoder dec_i
			(
				.digit (digits[k]),
				.seg   (seg[k])
			);
		end
	endgenerate

endmodule

`default_nettype wire

/* verif/tb_top_mdr.sv */
//==============================
// testbench for the multiply/divide/sqrt
// unit, replays verif/mdr_vectors.txt
//==============================
`default_nettype none

module tb_top_mdr import mdr_pkg::*;
();

	localparam int MAX_VEC = 32;	// room in the vector memory
	localparam int TIMEOUT = 40;	// cycles allowed for ready

	logic  clk;
	logic  reset;
	logic  load;
	logic  start;
	op_t   op;
	word_t data;
	word_t result;
	word_t remainder;
	logic  load_x;
	logic  load_y;
	logic  ready;
	logic  error;
	seg_t  seg [TAM-1:0];

	logic [7:0] vec [0:6*MAX_VEC-1];	// six bytes per test
	int         errors;
	int         checks;
	int         n;
	integer     seed;
	bit         timed_out;

	top_mdr top_mdr_i
	(
		.clk       (clk),
		.reset     (reset),
		.load      (load),
		.op        (op),
		.start     (start),
		.data      (data),
		.result    (result),
		.remainder (remainder),
		.load_x    (load_x),
		.load_y    (load_y),
		.ready     (ready),
		.error     (error),
		.seg       (seg)
	);

	always #4 clk = ~clk;

	//==============================
	// checking helpers
	//==============================
	task automatic check_value(input logic [15:0] got, input logic [15:0] exp,
		input string msg);
		checks++;
		if (got !== exp)
		begin
			$display("Fail at time %0t: %s, got %h expected %h", $time, msg, got, exp);
			errors++;
		end
	endtask

	// segments a..g, lit when high
	function automatic seg_t seg_pattern(input int d);
		case (d)
			0:       seg_pattern = 7'b1111110;
			1:       seg_pattern = 7'b0110000;
			2:       seg_pattern = 7'b1101101;
			3:       seg_pattern = 7'b1111001;
			4:       seg_pattern = 7'b0110011;
			5:       seg_pattern = 7'b1011011;
			6:       seg_pattern = 7'b1011111;
			7:       seg_pattern = 7'b1110000;
			8:       seg_pattern = 7'b1111111;
			9:       seg_pattern = 7'b1111011;
			default: seg_pattern = 7'b0000000;
		endcase
	endfunction

	// product for multiply, quotient or root otherwise
	task automatic check_display(input op_t o, input word_t res, input word_t rem);
		int value;
		int d;
		begin
			value = (o == OP_MUL) ? int'({rem, res}) : int'(res);
			for (int k = 0; k < TAM; k++)
			begin
				d     = value % 10;
				value = value / 10;
				check_value(16'(seg[k]), 16'(seg_pattern(d)), $sformatf("seg digit %0d", k));
			end
		end
	endtask

	//==============================
	// stimulus
	//==============================
	task automatic load_operand(input word_t value, input logic [1:0] flags);
		@(posedge clk);
		load <= 1'b1;
		data <= value;
		@(posedge clk);
		load <= 1'b0;
		@(negedge clk);
		check_value(16'({load_x, load_y}), 16'(flags), "load_x/load_y after a load");
	endtask

	task automatic start_and_wait(input op_t o, input int iter, input logic exp_err);
		int waited;
		begin
			waited = 0;
			@(posedge clk);
			op    <= o;	// held until ready
			start <= 1'b1;
			@(posedge clk);
			start <= 1'b0;	// the DUT takes start on this edge
			@(negedge clk);
			check_value(16'(ready), 16'd0, "ready the cycle after start");
			check_value(16'(error), 16'(exp_err), "error the cycle after start");
			while (!ready && waited < TIMEOUT)
			begin
				@(posedge clk);
				waited++;
				if (waited == 2)
					start <= 1'b1;	// stray start while busy
				else
					start <= 1'b0;
				@(negedge clk);
			end
			if (!ready)
			begin
				$display("ready did not rise within %0d cycles of start (time %0t)",
					TIMEOUT, $time);
				errors++;
				timed_out = 1'b1;
			end
			else
				check_value(16'(waited), 16'(iter + 1), "cycles from start to ready");
		end
	endtask

	task automatic run_vector(input int idx);
		op_t   v_op;
		word_t x;
		word_t y;
		word_t exp_res;
		word_t exp_rem;
		logic  exp_err;
		int    iter;
		int    gap;
		begin
			v_op    = op_t'(vec[6*idx][1:0]);
			x       = vec[6*idx+1];
			y       = vec[6*idx+2];
			exp_res = vec[6*idx+3];
			exp_rem = vec[6*idx+4];
			exp_err = vec[6*idx+5][0];
			iter    = (v_op == OP_SQRT) ? N/2 : N;	// sqrt takes two bits a step
			gap     = {$random(seed)} % 4;
			repeat (gap) @(posedge clk);
			load_operand(x, 2'b10);
			load_operand(y, 2'b11);
			start_and_wait(v_op, iter, exp_err);
			if (!timed_out)
			begin
				check_value(16'(result), 16'(exp_res), $sformatf("result of test %0d", idx));
				check_value(16'(remainder), 16'(exp_rem),
					$sformatf("remainder of test %0d", idx));
				check_value(16'(error), 16'(exp_err), $sformatf("error of test %0d", idx));
				check_display(v_op, exp_res, exp_rem);
			end
		end
	endtask

	//==============================
	// main sequence
	//==============================
	initial
	begin
		clk       = 1'b0;
		reset     = 1'b1;
		load      = 1'b0;
		start     = 1'b0;
		op        = OP_MUL;
		data      = '0;
		errors    = 0;
		checks    = 0;
		timed_out = 1'b0;
		seed      = 32'h92d8_bdfc;
		for (int a = 0; a < 6*MAX_VEC; a++)
			vec[a] = 8'hff;	// op ff marks the end of the list
		$readmemh("verif/mdr_vectors.txt", vec);

		repeat (8) @(posedge clk);
		reset <= 1'b0;
		@(negedge clk);
		check_value(16'(ready), 16'd1, "ready after reset");
		check_value(16'(error), 16'd0, "error after reset");
		check_value(16'({load_x, load_y}), 16'd0, "load flags after reset");
		check_value(16'({remainder, result}), 16'd0, "accumulator after reset");

		n = 0;
		while (n < MAX_VEC && vec[6*n] != 8'hff && !timed_out)
		begin
			run_vector(n);
			n++;
		end
		if (n == 0)
		begin
			$display("no test vectors were read from verif/mdr_vectors.txt");
			errors++;
		end

		$display("tests: %0d  checks: %0d  errors: %0d", n, checks, errors);
		if (errors == 0 && !timed_out)
			$display("*** PASSED ***");
		else
			$display("*** FAILED ***");
		$finish;
	end

endmodule

`default_nettype wire

/* verif/mdr_vectors.txt */
// columns, all hex: op x y result remainder error
// op 00 mul, 01 div, 02 sqrt, 03 reserved
00 ff ff 01 fe 00
00 00 5a 00 00 00
00 0c 0d 9c 00 00
00 80 02 00 01 00
00 7b 2d 9f 15 00
01 64 07 0e 02 00
01 05 09 00 05 00
01 ff 01 ff 00 00
01 c8 00 00 00 01
01 ff 10 0f 0f 00
00 03 05 0f 00 00
02 00 00 00 00 00
02 01 00 01 00 00
02 ff 00 0f 1e 00
02 51 00 09 00 00
02 90 00 0c 00 00
02 64 00 0a 00 00
02 32 00 07 01 00
03 12 34 00 00 01
02 e1 00 0f 00 00
01 07 64 00 07 00

/* vlog.f */
verilog/mdr_pkg.sv
verilog/operand_loader.sv
verilog/step_counter.sv
verilog/mdr_datapath.sv
verilog/bin_to_bcd.sv
verilog/seg7_decoder.sv
verilog/top_mdr.sv
verif/tb_top_mdr.sv

/* Makefile */
# Verilator build and run for the multiply/divide/sqrt unit
TOP = tb_top_mdr

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --top-module $(TOP) -Mdir obj_dir -f vlog.f

# pass only when the testbench prints the pass message
run: compile
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q -F '*** PASSED ***'

clean:
	rm -rf obj_dir
